// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    typedef enum logic [3:0] {
        IR_NONE  = 4'd0,
        IR_ALU_R = 4'd1,
        IR_ALU_I = 4'd2,
        IR_LUI   = 4'd3,
        IR_AUIPC = 4'd4,
        IR_CSRRW = 4'd5
    } ir_type_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_CSRRW   = 3'b001;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000; // SUB and SRA.

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // Reset defaults.
    localparam word_t   DEFAULT_PC   = 32'h0000_0000;
    localparam word_t   ZERO_WORD    = 32'h0000_0000;
    localparam funct7_t DEFAULT_F7   = 7'b0000000;
    localparam funct3_t DEFAULT_F3   = 3'b000;
    localparam logic    DEFAULT_WR_N = 1'b1;

endpackage

`default_nettype wire

// File: hdl/rv_decoder.sv
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     pc,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output funct7_t   funct7,
    output funct3_t   funct3,
    output csr_addr_t csr_addr,
    output ir_type_t  ir_type,
    output word_t     in2_imm,
    output logic      use_imm,
    output logic      wr_reg_n,
    output logic      wr_csr_n
);

    opcode_t opcode;
    word_t   imm_i;
    word_t   imm_u;
    logic    r_ok;
    logic    shift_ok;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7   = instr[31:25];
    assign csr_addr = instr[31:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'h000};

    // Alternate funct7 only for SUB and SRA.
    assign r_ok = (funct7 == F7_BASE) ||
                  (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

    // Shift immediates keep funct7 in the upper bits.
    assign shift_ok = (funct3 == F3_SLL)     ? (funct7 == F7_BASE) :
                      (funct3 == F3_SRL_SRA) ? (funct7 == F7_BASE || funct7 == F7_ALT) :
                      1'b1;

    always_comb begin
        ir_type = IR_NONE;
        if (instr_valid) begin
            case (opcode)
                OPC_OP:     ir_type = r_ok ? IR_ALU_R : IR_NONE;
                OPC_OP_IMM: ir_type = shift_ok ? IR_ALU_I : IR_NONE;
                OPC_LUI:    ir_type = IR_LUI;
                OPC_AUIPC:  ir_type = IR_AUIPC;
                OPC_SYSTEM: ir_type = (funct3 == F3_CSRRW) ? IR_CSRRW : IR_NONE;
                default:    ir_type = IR_NONE; // Unsupported, bubble.
            endcase
        end
    end

    always_comb begin
        case (ir_type)
            IR_ALU_I: in2_imm = imm_i;
            IR_LUI:   in2_imm = imm_u;
            IR_AUIPC: in2_imm = imm_u + pc;
            default:  in2_imm = ZERO_WORD;
        endcase
    end

    assign use_imm = (ir_type == IR_ALU_I) || (ir_type == IR_LUI) || (ir_type == IR_AUIPC);

    // Active low. A write to x0 is dropped here.
    assign wr_reg_n = (ir_type == IR_NONE) || (rd == 5'd0);
    assign wr_csr_n = (ir_type != IR_CSRRW);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    output word_t     data1,
    output word_t     data2
);

    word_t regs [1:31]; // x0 is not stored.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so a read in the write cycle sees the new value.
    assign data1 = (rs1 == 5'd0)          ? ZERO_WORD :
                   (we && wa == rs1)      ? wd :
                   regs[rs1];
    assign data2 = (rs2 == 5'd0)          ? ZERO_WORD :
                   (we && wa == rs2)      ? wd :
                   regs[rs2];

endmodule

`default_nettype wire

// File: hdl/id_ex_regs.sv
`default_nettype none

module id_ex_regs
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      pipeline_flush,

    input  word_t     pc_in,
    output word_t     pc_out,

    input  word_t     data1_in,
    input  word_t     data2_in,
    output word_t     data1_out,
    output word_t     data2_out,

    input  funct7_t   funct7_in,
    output funct7_t   funct7_out,

    input  funct3_t   funct3_in,
    output funct3_t   funct3_out,

    input  reg_addr_t rs1_in,
    input  reg_addr_t rs2_in,
    output reg_addr_t rs1_out,
    output reg_addr_t rs2_out,

    input  reg_addr_t rd_in,
    output reg_addr_t rd_out,

    input  csr_addr_t csr_addr_in,
    output csr_addr_t csr_addr_out,

    input  ir_type_t  ir_type_in,
    output ir_type_t  ir_type_out,

    input  logic      wr_reg_n_in,
    output logic      wr_reg_n_out,

    input  logic      wr_csr_n_in,
    output logic      wr_csr_n_out,

    input  logic      flush_in,
    output logic      flush_out,

    input  word_t     in2_in,
    output word_t     in2_out,

    input  logic      use_imm_in,
    output logic      use_imm_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out       <= DEFAULT_PC;
            data1_out    <= ZERO_WORD;
            data2_out    <= ZERO_WORD;
            funct7_out   <= DEFAULT_F7;
            funct3_out   <= DEFAULT_F3;
            rs1_out      <= 5'd0;
            rs2_out      <= 5'd0;
            rd_out       <= 5'd0;
            csr_addr_out <= 12'h000;
            ir_type_out  <= IR_NONE;
            wr_reg_n_out <= DEFAULT_WR_N;
            wr_csr_n_out <= DEFAULT_WR_N;
            flush_out    <= 1'b0;
            in2_out      <= ZERO_WORD;
            use_imm_out  <= 1'b0;
        end else if (stall) begin
            // Entry holds. The instruction already wrote in its first EX cycle.
            wr_reg_n_out <= 1'b1;
            wr_csr_n_out <= 1'b1;
        end else begin
            pc_out       <= pc_in;
            data1_out    <= data1_in;
            data2_out    <= data2_in;
            funct7_out   <= funct7_in;
            funct3_out   <= funct3_in;
            rs1_out      <= rs1_in;
            rs2_out      <= rs2_in;
            rd_out       <= rd_in;
            csr_addr_out <= csr_addr_in;
            ir_type_out  <= ir_type_in;
            wr_reg_n_out <= pipeline_flush ? 1'b1 : wr_reg_n_in; // Flushed, no write.
            wr_csr_n_out <= pipeline_flush ? 1'b1 : wr_csr_n_in;
            flush_out    <= pipeline_flush || flush_in;
            in2_out      <= in2_in;
            use_imm_out  <= use_imm_in;
        end
    end

endmodule

`default_nettype wire

// File: execute/ex_stage.sv
`default_nettype none

module ex_stage
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     pc,
    input  word_t     data1,
    input  word_t     data2,
    input  funct7_t   funct7,
    input  funct3_t   funct3,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  csr_addr_t csr_addr,
    input  ir_type_t  ir_type,
    input  logic      wr_reg_n,
    input  logic      wr_csr_n,
    input  word_t     in2,
    input  logic      use_imm,
    input  word_t     csr_rdata,
    output logic      csr_we,
    output csr_addr_t csr_waddr,
    output word_t     csr_wdata,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    word_t   op_a;
    word_t   op_b;
    word_t   rs2_val;
    word_t   alu_res;
    word_t   result;
    alu_op_t alu_op;

    // wb_rd is never x0 while wb_valid is high.
    assign op_a    = (wb_valid && wb_rd == rs1) ? wb_data : data1;
    assign rs2_val = (wb_valid && wb_rd == rs2) ? wb_data : data2;
    assign op_b    = use_imm ? in2 : rs2_val;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_op = (ir_type == IR_ALU_R && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL; // SRAI too.
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = word_t'(op_a < op_b);
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    always_comb begin
        case (ir_type)
            IR_LUI, IR_AUIPC: result = in2; // pc already added in decode.
            IR_CSRRW:         result = csr_rdata;
            default:          result = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            csr_we   <= 1'b0;
        end else begin
            wb_valid <= !wr_reg_n;
            csr_we   <= !wr_csr_n;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd     <= rd;
        wb_data   <= result;
        csr_waddr <= csr_addr;
        csr_wdata <= op_a; // New CSR value from rs1.
    end

endmodule

`default_nettype wire

// File: hdl/csr_file.sv
`default_nettype none

module csr_file
    import rv_pkg::*;
#(
    parameter word_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t raddr,
    input  logic      we,
    input  csr_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata
);

    word_t mscratch;
    word_t mtvec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= ZERO_WORD;
            mtvec    <= MTVEC_RESET;
        end else if (we) begin
            case (waddr)
                CSR_MSCRATCH: mscratch <= wdata;
                CSR_MTVEC:    mtvec    <= wdata;
                default:      ; // Unknown CSR, ignored.
            endcase
        end
    end

    // Pending write is visible to a back-to-back CSRRW.
    always_comb begin
        case (raddr)
            CSR_MSCRATCH: rdata = (we && waddr == CSR_MSCRATCH) ? wdata : mscratch;
            CSR_MTVEC:    rdata = (we && waddr == CSR_MTVEC) ? wdata : mtvec;
            default:      rdata = ZERO_WORD;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pipe_slice_top.sv
`default_nettype none

module pipe_slice_top
    import rv_pkg::*;
#(
    parameter word_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     pc,
    input  logic      stall,
    input  logic      pipeline_flush,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    funct7_t   dec_funct7;
    funct3_t   dec_funct3;
    csr_addr_t dec_csr_addr;
    ir_type_t  dec_ir_type;
    word_t     dec_in2;
    logic      dec_use_imm, dec_wr_reg_n, dec_wr_csr_n;
    word_t     rf_data1, rf_data2;

    word_t     ex_pc, ex_data1, ex_data2, ex_in2;
    funct7_t   ex_funct7;
    funct3_t   ex_funct3;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    csr_addr_t ex_csr_addr;
    ir_type_t  ex_ir_type;
    logic      ex_wr_reg_n, ex_wr_csr_n, ex_use_imm;
    logic      ex_flush; // Flush marker of the EX entry.

    word_t     csr_rdata, csr_wdata;
    csr_addr_t csr_waddr;
    logic      csr_we;

    rv_decoder u_dec (
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .funct7(dec_funct7), .funct3(dec_funct3), .csr_addr(dec_csr_addr),
        .ir_type(dec_ir_type), .in2_imm(dec_in2), .use_imm(dec_use_imm),
        .wr_reg_n(dec_wr_reg_n), .wr_csr_n(dec_wr_csr_n)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .rs1(dec_rs1), .rs2(dec_rs2),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data),
        .data1(rf_data1), .data2(rf_data2)
    );

    id_ex_regs u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall(stall), .pipeline_flush(pipeline_flush),
        .pc_in(pc), .pc_out(ex_pc),
        .data1_in(rf_data1), .data2_in(rf_data2),
        .data1_out(ex_data1), .data2_out(ex_data2),
        .funct7_in(dec_funct7), .funct7_out(ex_funct7),
        .funct3_in(dec_funct3), .funct3_out(ex_funct3),
        .rs1_in(dec_rs1), .rs2_in(dec_rs2), .rs1_out(ex_rs1), .rs2_out(ex_rs2),
        .rd_in(dec_rd), .rd_out(ex_rd),
        .csr_addr_in(dec_csr_addr), .csr_addr_out(ex_csr_addr),
        .ir_type_in(dec_ir_type), .ir_type_out(ex_ir_type),
        .wr_reg_n_in(dec_wr_reg_n), .wr_reg_n_out(ex_wr_reg_n),
        .wr_csr_n_in(dec_wr_csr_n), .wr_csr_n_out(ex_wr_csr_n),
        .flush_in(1'b0), .flush_out(ex_flush), // No earlier stage to flush.
        .in2_in(dec_in2), .in2_out(ex_in2),
        .use_imm_in(dec_use_imm), .use_imm_out(ex_use_imm)
    );

    ex_stage u_ex (
        .clk(clk), .rst_n(rst_n), .pc(ex_pc), .data1(ex_data1), .data2(ex_data2),
        .funct7(ex_funct7), .funct3(ex_funct3), .rs1(ex_rs1), .rs2(ex_rs2),
        .rd(ex_rd), .csr_addr(ex_csr_addr), .ir_type(ex_ir_type),
        .wr_reg_n(ex_wr_reg_n), .wr_csr_n(ex_wr_csr_n), .in2(ex_in2),
        .use_imm(ex_use_imm), .csr_rdata(csr_rdata),
        .csr_we(csr_we), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    csr_file #(.MTVEC_RESET(MTVEC_RESET)) u_csr (
        .clk(clk), .rst_n(rst_n), .raddr(ex_csr_addr),
        .we(csr_we), .waddr(csr_waddr), .wdata(csr_wdata), .rdata(csr_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/tb_pipe_slice.sv
`default_nettype none

module tb_pipe_slice
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    PERIOD      = 100;
    localparam word_t MTVEC_RESET = 32'h0000_1a00;
    localparam int    NUM_RANDOM  = 600;
    localparam int    MAX_CYCLES  = 100 + NUM_RANDOM * 6; // Longest random step is 5 cycles.

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_exp_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    word_t     pc;
    logic      stall;
    logic      pipeline_flush;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     lfsr = 32'h938c633a;
    word_t     model_regs [32];
    word_t     model_mscratch;
    word_t     model_mtvec;
    wb_exp_t   exp_q [$]; // One entry per cycle after reset.
    logic      exp_flush = 1'b0; // Flush marker expected in the EX entry.
    logic      last_stall = 1'b0;
    logic      last_flush = 1'b0;

    pipe_slice_top #(.MTVEC_RESET(MTVEC_RESET)) UUT (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .stall(stall), .pipeline_flush(pipeline_flush),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1.
    function automatic word_t lfsr_step(word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        word_t       cls;
        word_t       w;
        rd  = 5'(rand_bits(3)); // Few registers, many dependences.
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        f3  = 3'(rand_bits(3));
        f7  = (rand_bits(2) == 0) ? 7'h20 : 7'h00;
        imm = (f3 == 3'd1 || f3 == 3'd5) ? {f7, rs2} : 12'(rand_bits(12));
        cls = rand_bits(3);
        case (cls)
            0, 1:    w = enc_r(f7, rs2, rs1, f3, rd);
            2, 3:    w = enc_i(imm, rs1, f3, rd, 7'b0010011);
            4:       w = enc_u(20'(rand_bits(20)), rd, 7'b0110111);
            5:       w = enc_u(20'(rand_bits(20)), rd, 7'b0010111);
            6:       w = enc_i((rand_bits(1) != 0) ? CSR_MTVEC : CSR_MSCRATCH,
                               rs1, 3'b001, rd, 7'b1110011);
            default: w = enc_i(imm, rs1, f3, rd, 7'b0000011); // A load, unsupported.
        endcase
        return w;
    endfunction

    // Executes in program order, so it needs no forwarding of its own.
    task automatic model_exec(input word_t ins, input word_t p, output wb_exp_t e);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        word_t      a;
        word_t      b;
        word_t      res;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = model_regs[ins[19:15]];
        b   = (opc == 7'b0010011) ? {{20{ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
        res = '0;
        case (opc)
            7'b0110011: ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            7'b0010011: ok = (f3 == 3'd1) ? f7 == 7'h00 :
                             (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            7'b0110111, 7'b0010111: ok = 1'b1;
            7'b1110011: ok = f3 == 3'd1;
            default:    ok = 1'b0; // Bubble.
        endcase
        if (opc == 7'b0110011 || opc == 7'b0010011) begin
            case (f3)
                3'd0: res = (opc == 7'b0110011 && f7[5]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = {31'd0, $signed(a) < $signed(b)};
                3'd3: res = {31'd0, a < b};
                3'd4: res = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else if (opc == 7'b0110111) begin
            res = {ins[31:12], 12'h000};
        end else if (opc == 7'b0010111) begin
            res = p + {ins[31:12], 12'h000};
        end else if (ok) begin
            // Old value out, rs1 in.
            if (ins[31:20] == CSR_MSCRATCH) begin
                res = model_mscratch;
                model_mscratch = a;
            end else if (ins[31:20] == CSR_MTVEC) begin
                res = model_mtvec;
                model_mtvec = a;
            end
        end
        e.valid = ok && ins[11:7] != 5'd0;
        e.rd    = ins[11:7];
        e.data  = res;
        if (e.valid) begin
            model_regs[e.rd] = res;
        end
    endtask

    task automatic issue(input logic v, input word_t ins, input word_t p,
                         input logic st, input logic fl);
        wb_exp_t e;
        e = '0;
        @(posedge clk);
        // The entry taken at this edge saw last cycle's stall and flush.
        if (!last_stall) begin
            exp_flush = last_flush;
        end
        last_stall = st;
        last_flush = fl;
        instr_valid    <= v;
        instr          <= ins;
        pc             <= p;
        stall          <= st;
        pipeline_flush <= fl;
        if (v && !fl) begin
            model_exec(ins, p, e);
        end
        exp_q.push_back(e);
    endtask

    task automatic strobe(input word_t ins);
        issue(1'b1, ins, rand_bits(30) << 2, 1'b0, 1'b0);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            issue(1'b0, '0, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic check_failed(input string what, input word_t got, input word_t want);
        $display("error %0t ns: %s is %h, expected %h", $time, what, got, want);
        $display("Regression failed");
        $fatal(1, "output check failed");
    endtask

    // Compares the cycle against the entry pushed two cycles earlier.
    always @(negedge clk) begin
        wb_exp_t e;
        assert (UUT.ex_flush === exp_flush)
            else check_failed("flush_out", word_t'(UUT.ex_flush), word_t'(exp_flush));
        if (!rst_n) begin
            assert (wb_valid === 1'b0)
                else check_failed("wb_valid in reset", word_t'(wb_valid), 32'd0);
        end else if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            assert (wb_valid === e.valid)
                else check_failed("wb_valid", word_t'(wb_valid), word_t'(e.valid));
            if (e.valid) begin
                assert (wb_rd === e.rd) else check_failed("wb_rd", word_t'(wb_rd), word_t'(e.rd));
                assert (wb_data === e.data) else check_failed("wb_data", wb_data, e.data);
            end
        end
    end

    initial begin
        #(MAX_CYCLES * PERIOD);
        $display("Regression failed");
        $fatal(1, "watchdog timeout, the run did not reach its end");
    end

    initial begin
        int gap;
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        pc             = '0;
        stall          = 1'b0;
        pipeline_flush = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_mscratch = '0;
        model_mtvec    = MTVEC_RESET;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);

        // CSR swaps from reset values, back to back and at distance two.
        strobe(enc_u(20'h12345, 5'd3, 7'b0110111));
        strobe(enc_i(CSR_MTVEC, 5'd3, 3'b001, 5'd1, 7'b1110011));
        strobe(enc_i(CSR_MTVEC, 5'd0, 3'b001, 5'd2, 7'b1110011));
        strobe(enc_i(CSR_MSCRATCH, 5'd1, 3'b001, 5'd4, 7'b1110011));
        idle(1);
        strobe(enc_i(CSR_MSCRATCH, 5'd2, 3'b001, 5'd5, 7'b1110011));

        strobe(enc_i(12'd100, 5'd0, 3'b000, 5'd6, 7'b0010011));
        strobe(enc_r(7'h00, 5'd6, 5'd6, 3'b000, 5'd7)); // Distance one.
        strobe(enc_r(7'h20, 5'd6, 5'd7, 3'b000, 5'd8)); // Distance one and two.
        strobe(enc_i(12'hfff, 5'd8, 3'b000, 5'd0, 7'b0010011));

        // x9 must stay zero.
        issue(1'b1, enc_i(12'd55, 5'd0, 3'b000, 5'd9, 7'b0010011), '0, 1'b0, 1'b1);
        strobe(enc_r(7'h00, 5'd0, 5'd9, 3'b000, 5'd10));
        idle(1);
        strobe(enc_r(7'h00, 5'd0, 5'd9, 3'b000, 5'd11));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue(1'b1, random_instr(), rand_bits(30) << 2, 1'b0, rand_bits(4) == 0);
            if (rand_bits(3) == 0) begin
                gap = 1 + int'(rand_bits(2));
                for (int s = 0; s < gap; s++) begin
                    issue(1'b0, '0, '0, 1'b1, 1'b0);
                end
            end else if (rand_bits(2) == 0) begin
                idle(1);
            end
        end
        idle(4);
        @(posedge clk);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/rv_pkg.sv
hdl/rv_decoder.sv
hdl/reg_file.sv
hdl/id_ex_regs.sv
execute/ex_stage.sv
hdl/csr_file.sv
hdl/pipe_slice_top.sv
testbench/tb_pipe_slice.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_slice
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
